/* bench/trapUnitTb.sv */
`timescale 1ns/1ns

module trapUnitTb;
    import trapPkg::*;

    localparam int NUM_RANDOM     = 40;
    localparam int TIMEOUT_CYCLES = 400 + NUM_RANDOM * 40;

    logic        clk = 1'b0;
    logic        arstN;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    regAddr_t    wbAdr;
    word_t       wbDatIn;
    word_t       wbDatOut;
    logic        wbAck;
    retireInfo_t retire;
    logic        trapTaken;
    excCause_t   excCause;
    word_t       trapTarget;
    word_t       expMtvec;
    integer      seed = 32'hdd36;

    trapUnit u_trapUnit (
        .clk          (clk),
        .arstN_i      (arstN),
        .wbCyc_i      (wbCyc),
        .wbStb_i      (wbStb),
        .wbWe_i       (wbWe),
        .wbAdr_i      (wbAdr),
        .wbDat_i      (wbDatIn),
        .wbDat_o      (wbDatOut),
        .wbAck_o      (wbAck),
        .retire_i     (retire),
        .trapTaken_o  (trapTaken),
        .excCause_o   (excCause),
        .trapTarget_o (trapTarget)
    );

    always #50 clk = ~clk;

    task automatic abortRun();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            abortRun();
        end
    endtask

    task automatic checkCause(input string name, input excCause_t got, input excCause_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            abortRun();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, got);
            abortRun();
        end
    endtask

    // Holds the request until ack, sampled 5 ns after the edge
    task automatic wbAccess(input logic we, input regAddr_t adr, input word_t wdata,
                            output word_t rdata);
        wbCyc   = 1'b1;
        wbStb   = 1'b1;
        wbWe    = we;
        wbAdr   = adr;
        wbDatIn = wdata;
        do begin
            @(posedge clk);
            #5;
        end while (!wbAck);
        rdata = wbDatOut;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbWrite(input regAddr_t adr, input word_t wdata);
        word_t unused;
        wbAccess(1'b1, adr, wdata, unused);
    endtask

    task automatic wbRead(input regAddr_t adr, output word_t rdata);
        wbAccess(1'b0, adr, '0, rdata);
    endtask

    function automatic retireInfo_t cleanInst(input word_t pc);
        retireInfo_t r;
        r             = '0;
        r.valid       = 1'b1;
        r.pc          = pc;
        r.memInstType = MEM_NONE;
        return r;
    endfunction

    // Expected data-side result from range, exemption and access size
    function automatic void dataExpect(input memInstType_t op, input word_t addr,
                                       output logic present, output excCause_t cause);
        logic        store;
        logic        inRange;
        int unsigned size;
        store   = (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
        inRange = ((addr >= MEM_VALID_RANGE_BASE) && (addr <= MEM_VALID_RANGE_LIMIT)) ||
                  (addr == MMIO_EXEMPT_ADDR);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: size = 2;
            MEM_LW, MEM_SW:          size = 4;
            default:                 size = 1;
        endcase
        present = 1'b0;
        cause   = '0;
        if (op != MEM_NONE && !inRange) begin
            present = 1'b1;
            cause   = store ? M_STORE_AFAULT : M_LOAD_AFAULT;
        end else if (op != MEM_NONE && (addr % size) != 0) begin
            present = 1'b1;
            cause   = store ? M_STORE_MISALIGN : M_LOAD_MISALIGN;
        end
    endfunction

    task automatic retireCheck(input retireInfo_t r, input logic expTrap,
                               input excCause_t expCause, input word_t expInfo);
        word_t rd;
        @(posedge clk);
        #5;
        retire = r;
        #1;
        checkBit("trapTaken_o", trapTaken, expTrap);
        checkWord("trapTarget_o", trapTarget, expMtvec);
        if (expTrap) begin
            checkCause("excCause_o", excCause, expCause);
        end
        @(posedge clk);
        #5;
        retire.valid = 1'b0;
        if (expTrap) begin
            wbRead(REG_MEPC, rd);
            checkWord("mepc", rd, r.pc);
            wbRead(REG_MCAUSE, rd);
            checkCause("mcause", excCause_t'(rd), expCause);
            wbRead(REG_MTVAL, rd);
            checkWord("mtval", rd, expInfo);
        end
    endtask

    task automatic testRegisters();
        word_t rd;
        wbRead(REG_MTIMECMP, rd);
        checkWord("mtimecmp", rd, '1);
        for (int a = int'(REG_MTVEC); a <= int'(REG_MSTATUS); a++) begin
            wbRead(regAddr_t'(a), rd);
            checkWord($sformatf("reg %0d after reset", a), rd, '0);
        end
        wbWrite(REG_MTVEC, 32'h0000_2003);
        expMtvec = 32'h0000_2000;
        wbRead(REG_MTVEC, rd);
        checkWord("mtvec", rd, expMtvec);
        // Read-only and unmapped words ignore writes
        for (int a = int'(REG_MEPC); a <= 7; a++) begin
            if (a != int'(REG_MSTATUS)) begin
                wbWrite(regAddr_t'(a), $random(seed));
                wbRead(regAddr_t'(a), rd);
                checkWord($sformatf("reg %0d after write", a), rd, '0);
            end
        end
        wbWrite(REG_MTIME, 32'hFFFF_0000);
        wbRead(REG_MTIME, rd);
        checkBit("mtime ignores writes", rd < 32'd1000, 1'b1);
    endtask

    task automatic testPcPriority();
        retireInfo_t r;
        r            = cleanInst(32'h0000_1100);
        r.shouldJump = 1'b1;
        r.pcJumpDst  = 32'h0000_1202;
        retireCheck(r, 1'b1, M_INSTR_MISALIGN, 32'h0000_1202);
        retireCheck(cleanInst(32'h0000_0800), 1'b1, M_INSTR_AFAULT, 32'h0000_0800);
        r             = cleanInst(32'h0000_1104);
        r.instInvalid = 1'b1;
        retireCheck(r, 1'b1, M_ILL_INSTR, 32'h0000_1104);
        // Stacked conditions, the highest one wins
        r             = cleanInst(32'h0000_9000);
        r.instInvalid = 1'b1;
        r.priv        = 1'b1;
        r.shouldJump  = 1'b1;
        r.pcJumpDst   = 32'h0000_1001;
        retireCheck(r, 1'b1, M_INSTR_MISALIGN, 32'h0000_1001);
        r.pcJumpDst = 32'h0000_1000;
        retireCheck(r, 1'b1, M_INSTR_AFAULT, 32'h0000_9000);
        r.pc = 32'h0000_1108;
        retireCheck(r, 1'b1, M_ILL_INSTR, 32'h0000_1108);
    endtask

    task automatic testDataFaults();
        retireInfo_t r;
        word_t       rnd;
        word_t       addr;
        logic        present;
        excCause_t   cause;
        r             = cleanInst(32'h0000_1300);
        r.memInstType = MEM_LB;
        r.dataAddress = 32'h0000_8001;
        retireCheck(r, 1'b0, '0, '0);
        r.memInstType = MEM_SW;
        r.dataAddress = MMIO_EXEMPT_ADDR;
        retireCheck(r, 1'b0, '0, '0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd  = $random(seed);
            addr = $random(seed);
            case (rnd[1:0])
                2'd0, 2'd1: addr = {16'h0000, 1'b1, addr[14:0]};
                2'd2:       addr = MMIO_EXEMPT_ADDR | {30'h0, addr[1:0]};
                default: begin
                end
            endcase
            r.memInstType = (rnd[10:8] == 3'd0) ? MEM_NONE : memInstType_t'({1'b1, rnd[6:4]});
            r.dataAddress = addr;
            dataExpect(r.memInstType, addr, present, cause);
            retireCheck(r, present, cause, addr);
        end
    endtask

    task automatic testPrivileged();
        retireInfo_t r;
        r             = cleanInst(32'h0000_1200);
        r.priv        = 1'b1;
        r.privCause   = 32'd11;
        r.memInstType = MEM_LW;
        r.dataAddress = 32'h0000_0003;
        retireCheck(r, 1'b1, 32'd11, 32'h0000_1200);
        r.privCause = 32'd3;
        retireCheck(r, 1'b1, 32'd3, 32'h0000_1200);
    endtask

    task automatic testTimer();
        word_t rd;
        word_t cmp;
        wbRead(REG_MTIME, rd);
        cmp = rd + 32'd20;
        wbWrite(REG_MTIMECMP, cmp);
        wbWrite(REG_MSTATUS, 32'h0000_0008);
        wbRead(REG_MSTATUS, rd);
        checkWord("mstatus", rd, 32'h0000_0008);
        do begin
            wbRead(REG_MTIME, rd);
        end while (rd < cmp + 32'd2);
        retireCheck(cleanInst(32'h0000_1400), 1'b1, M_TIMER_INT, '0);
        wbRead(REG_MSTATUS, rd);
        checkWord("mstatus after trap", rd, '0);
        retireCheck(cleanInst(32'h0000_1404), 1'b0, '0, '0);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        abortRun();
    end

    initial begin
        arstN    = 1'b0;
        wbCyc    = 1'b0;
        wbStb    = 1'b0;
        wbWe     = 1'b0;
        wbAdr    = '0;
        wbDatIn  = '0;
        retire   = '0;
        expMtvec = '0;
        repeat (8) @(posedge clk);
        #5;
        arstN = 1'b1;
        testRegisters();
        testPcPriority();
        testDataFaults();
        testPrivileged();
        testTimer();
        $display("Test passed");
        $finish;
    end

endmodule

/* bench/trapUnit_checker.sv */
`timescale 1ns/1ns

module trapUnit_checker (
    input logic clk,
    input logic arstN_i,
    input logic wbCyc_i,
    input logic wbStb_i,
    input logic wbAck_i,
    input logic retireValid_i,
    input logic trapTaken_i,
    input logic mie_i
);

    // Ack is a single-cycle pulse
    ackSinglePulse: assert property (
        @(posedge clk) disable iff (!arstN_i)
        wbAck_i |=> !wbAck_i
    ) else $error("wbAck_o stayed high for two cycles");

    ackAfterRequest: assert property (
        @(posedge clk) disable iff (!arstN_i)
        wbAck_i |-> $past(wbCyc_i && wbStb_i)
    ) else $error("wbAck_o raised without a preceding cyc and stb");

    trapNeedsRetire: assert property (
        @(posedge clk) disable iff (!arstN_i)
        trapTaken_i |-> retireValid_i
    ) else $error("trapTaken_o high without a valid retire");

    // Trap entry disables interrupts
    trapClearsMie: assert property (
        @(posedge clk) disable iff (!arstN_i)
        trapTaken_i |=> !mie_i
    ) else $error("MIE still set in the cycle after a trap");

endmodule

bind trapUnit trapUnit_checker u_trapUnitChecker (
    .clk           (clk),
    .arstN_i       (arstN_i),
    .wbCyc_i       (wbCyc_i),
    .wbStb_i       (wbStb_i),
    .wbAck_i       (wbAck_o),
    .retireValid_i (retire_i.valid),
    .trapTaken_i   (trapTaken_o),
    .mie_i         (u_trapCsr.mstatusMie)
);

/* hw/excDetect.sv */
`timescale 1ns/1ns

module excDetect (
    input  logic                 mtimeExc_i,
    input  trapPkg::retireInfo_t retire_i,
    output trapPkg::excReport_t  report_o
);
    import trapPkg::*;

    logic isLoad;
    logic isStore;
    logic isHalf;
    logic isWord;
    logic memAccess;
    logic jumpMisaligned;
    logic pcOutOfRange;
    logic dataOutOfRange;
    logic dataMisaligned;

    // Classify the access
    always_comb begin
        isLoad  = 1'b0;
        isStore = 1'b0;
        isHalf  = 1'b0;
        isWord  = 1'b0;
        case (retire_i.memInstType)
            MEM_LB, MEM_LBU: begin
                isLoad = 1'b1;
            end
            MEM_LH, MEM_LHU: begin
                isLoad = 1'b1;
                isHalf = 1'b1;
            end
            MEM_LW: begin
                isLoad = 1'b1;
                isWord = 1'b1;
            end
            MEM_SB: begin
                isStore = 1'b1;
            end
            MEM_SH: begin
                isStore = 1'b1;
                isHalf  = 1'b1;
            end
            MEM_SW: begin
                isStore = 1'b1;
                isWord  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign memAccess = isLoad | isStore;

    assign jumpMisaligned = retire_i.shouldJump && (retire_i.pcJumpDst[1:0] != 2'b00);

    assign pcOutOfRange = (retire_i.pc < PC_VALID_RANGE_BASE) ||
                          (retire_i.pc > PC_VALID_RANGE_LIMIT);

    // MMIO word sits outside the data range but is still legal
    assign dataOutOfRange = (retire_i.dataAddress != MMIO_EXEMPT_ADDR) &&
                            ((retire_i.dataAddress < MEM_VALID_RANGE_BASE) ||
                             (retire_i.dataAddress > MEM_VALID_RANGE_LIMIT));

    // Halfword at offset 1 or 3, word at any nonzero offset
    assign dataMisaligned = (isHalf && retire_i.dataAddress[0]) ||
                            (isWord && (retire_i.dataAddress[1:0] != 2'b00));

    // Priority chain, highest first
    always_comb begin
        report_o = '0;
        if (jumpMisaligned) begin
            report_o.present = 1'b1;
            report_o.cause   = M_INSTR_MISALIGN;
            report_o.info    = retire_i.pcJumpDst;
        end else if (pcOutOfRange) begin
            report_o.present = 1'b1;
            report_o.cause   = M_INSTR_AFAULT;
            report_o.info    = retire_i.pc;
        end else if (retire_i.instInvalid) begin
            report_o.present = 1'b1;
            report_o.cause   = M_ILL_INSTR;
            report_o.info    = retire_i.pc;
        end else if (retire_i.priv) begin
            report_o.present = 1'b1;
            report_o.cause   = retire_i.privCause;
            report_o.info    = retire_i.pc;
        end else if (memAccess && dataOutOfRange) begin
            report_o.present = 1'b1;
            report_o.cause   = isLoad ? M_LOAD_AFAULT : M_STORE_AFAULT;
            report_o.info    = retire_i.dataAddress;
        end else if (memAccess && dataMisaligned) begin
            report_o.present = 1'b1;
            report_o.cause   = isLoad ? M_LOAD_MISALIGN : M_STORE_MISALIGN;
            report_o.info    = retire_i.dataAddress;
        end else if (mtimeExc_i) begin
            // Interrupt carries no trap value
            report_o.present = 1'b1;
            report_o.cause   = M_TIMER_INT;
        end
    end

endmodule

/* hw/machineTimer.sv */
`timescale 1ns/1ns

module machineTimer (
    input  logic             clk,
    input  logic             arstN_i,
    input  trapPkg::regReq_t req_i,
    output trapPkg::word_t   mtime_o,
    output trapPkg::word_t   mtimecmp_o,
    output logic             timerPending_o
);
    import trapPkg::*;

    word_t mtime;
    word_t mtimecmp;
    logic  timerPending;

    // Free running, not writable from the bus
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + word_t'(1);
        end
    end

    // All ones keeps the interrupt quiet out of reset
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            mtimecmp <= '1;
        end else if (req_i.wr && (req_i.addr == REG_MTIMECMP)) begin
            mtimecmp <= req_i.wdata;
        end
    end

    // Registered compare, so a new mtimecmp is seen one cycle later
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            timerPending <= 1'b0;
        end else begin
            timerPending <= (mtime >= mtimecmp);
        end
    end

    assign mtime_o        = mtime;
    assign mtimecmp_o     = mtimecmp;
    assign timerPending_o = timerPending;

endmodule

/* hw/trapCsr.sv */
`timescale 1ns/1ns

module trapCsr (
    input  logic                 clk,
    input  logic                 arstN_i,
    input  trapPkg::regReq_t     req_i,
    input  trapPkg::retireInfo_t retire_i,
    input  logic                 timerPending_i,
    output trapPkg::word_t       rdata_o,
    output logic                 trapTaken_o,
    output trapPkg::excCause_t   excCause_o,
    output trapPkg::word_t       trapTarget_o
);
    import trapPkg::*;

    word_t      mtvec;
    word_t      mepc;
    excCause_t  mcause;
    word_t      mtval;
    logic       mstatusMie;
    logic       mtimeExc;
    excReport_t report;

    // Interrupt only requested while globally enabled
    assign mtimeExc = timerPending_i & mstatusMie;

    excDetect u_excDetect (
        .mtimeExc_i (mtimeExc),
        .retire_i   (retire_i),
        .report_o   (report)
    );

    assign trapTaken_o  = retire_i.valid & report.present;
    assign excCause_o   = report.cause;
    assign trapTarget_o = mtvec;

    // Direct mode only, base is word aligned
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            mtvec <= '0;
        end else if (req_i.wr && (req_i.addr == REG_MTVEC)) begin
            mtvec <= {req_i.wdata[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (trapTaken_o) begin
            mepc   <= retire_i.pc;
            mcause <= report.cause;
            mtval  <= report.info;
        end
    end

    // Trap entry wins over a same-cycle mstatus write
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            mstatusMie <= 1'b0;
        end else if (trapTaken_o) begin
            mstatusMie <= 1'b0;
        end else if (req_i.wr && (req_i.addr == REG_MSTATUS)) begin
            mstatusMie <= req_i.wdata[MSTATUS_MIE_BIT];
        end
    end

    always_comb begin
        rdata_o = '0;
        case (req_i.addr)
            REG_MTVEC:   rdata_o = mtvec;
            REG_MEPC:    rdata_o = mepc;
            REG_MCAUSE:  rdata_o = mcause;
            REG_MTVAL:   rdata_o = mtval;
            REG_MSTATUS: rdata_o[MSTATUS_MIE_BIT] = mstatusMie;
            default: begin
            end
        endcase
    end

endmodule

/* hw/trapPkg.sv */
package trapPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 3;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       excCause_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;

    // mcause codes, interrupt flag in the top bit
    localparam excCause_t M_INSTR_MISALIGN = 32'd0;
    localparam excCause_t M_INSTR_AFAULT   = 32'd1;
    localparam excCause_t M_ILL_INSTR      = 32'd2;
    localparam excCause_t M_LOAD_MISALIGN  = 32'd4;
    localparam excCause_t M_LOAD_AFAULT    = 32'd5;
    localparam excCause_t M_STORE_MISALIGN = 32'd6;
    localparam excCause_t M_STORE_AFAULT   = 32'd7;
    localparam excCause_t M_TIMER_INT      = 32'h8000_0007;

    // Memory ops all carry bit 3
    typedef enum logic [3:0] {
        MEM_NONE = 4'h0,
        MEM_LB   = 4'h8,
        MEM_LH   = 4'h9,
        MEM_LW   = 4'hA,
        MEM_LBU  = 4'hB,
        MEM_LHU  = 4'hC,
        MEM_SB   = 4'hD,
        MEM_SH   = 4'hE,
        MEM_SW   = 4'hF
    } memInstType_t;

    localparam word_t PC_VALID_RANGE_BASE   = 32'h0000_1000;
    localparam word_t PC_VALID_RANGE_LIMIT  = 32'h0000_7FFF;
    localparam word_t MEM_VALID_RANGE_BASE  = 32'h0000_8000;
    localparam word_t MEM_VALID_RANGE_LIMIT = 32'h0000_FFFF;
    localparam word_t MMIO_EXEMPT_ADDR      = 32'h0000_0100;

    // Register map, word index
    localparam regAddr_t REG_MTIME    = 3'd0;
    localparam regAddr_t REG_MTIMECMP = 3'd1;
    localparam regAddr_t REG_MTVEC    = 3'd2;
    localparam regAddr_t REG_MEPC     = 3'd3;
    localparam regAddr_t REG_MCAUSE   = 3'd4;
    localparam regAddr_t REG_MTVAL    = 3'd5;
    localparam regAddr_t REG_MSTATUS  = 3'd6;

    localparam int MSTATUS_MIE_BIT = 3;

    typedef struct packed {
        logic         valid;
        logic         shouldJump;
        word_t        pcJumpDst;
        word_t        pc;
        word_t        dataAddress;
        memInstType_t memInstType;
        logic         instInvalid;
        logic         priv;
        excCause_t    privCause;
    } retireInfo_t;

    typedef struct packed {
        logic      present;
        excCause_t cause;
        word_t     info;
    } excReport_t;

    typedef struct packed {
        logic     wr;
        regAddr_t addr;
        word_t    wdata;
    } regReq_t;

endpackage

/* hw/trapUnit.sv */
`timescale 1ns/1ns

module trapUnit (
    input  logic                 clk,
    input  logic                 arstN_i,
    input  logic                 wbCyc_i,
    input  logic                 wbStb_i,
    input  logic                 wbWe_i,
    input  trapPkg::regAddr_t    wbAdr_i,
    input  trapPkg::word_t       wbDat_i,
    output trapPkg::word_t       wbDat_o,
    output logic                 wbAck_o,
    input  trapPkg::retireInfo_t retire_i,
    output logic                 trapTaken_o,
    output trapPkg::excCause_t   excCause_o,
    output trapPkg::word_t       trapTarget_o
);
    import trapPkg::*;

    regReq_t regReq;
    word_t   csrRdata;
    word_t   mtime;
    word_t   mtimecmp;
    logic    timerPending;

    wbRegBus u_wbRegBus (
        .clk        (clk),
        .arstN_i    (arstN_i),
        .wbCyc_i    (wbCyc_i),
        .wbStb_i    (wbStb_i),
        .wbWe_i     (wbWe_i),
        .wbAdr_i    (wbAdr_i),
        .wbDat_i    (wbDat_i),
        .wbDat_o    (wbDat_o),
        .wbAck_o    (wbAck_o),
        .req_o      (regReq),
        .csrRdata_i (csrRdata),
        .mtime_i    (mtime),
        .mtimecmp_i (mtimecmp)
    );

    machineTimer u_machineTimer (
        .clk            (clk),
        .arstN_i        (arstN_i),
        .req_i          (regReq),
        .mtime_o        (mtime),
        .mtimecmp_o     (mtimecmp),
        .timerPending_o (timerPending)
    );

    trapCsr u_trapCsr (
        .clk            (clk),
        .arstN_i        (arstN_i),
        .req_i          (regReq),
        .retire_i       (retire_i),
        .timerPending_i (timerPending),
        .rdata_o        (csrRdata),
        .trapTaken_o    (trapTaken_o),
        .excCause_o     (excCause_o),
        .trapTarget_o   (trapTarget_o)
    );

endmodule

/* hw/wbRegBus.sv */
`timescale 1ns/1ns

module wbRegBus (
    input  logic              clk,
    input  logic              arstN_i,
    input  logic              wbCyc_i,
    input  logic              wbStb_i,
    input  logic              wbWe_i,
    input  trapPkg::regAddr_t wbAdr_i,
    input  trapPkg::word_t    wbDat_i,
    output trapPkg::word_t    wbDat_o,
    output logic              wbAck_o,
    output trapPkg::regReq_t  req_o,
    input  trapPkg::word_t    csrRdata_i,
    input  trapPkg::word_t    mtime_i,
    input  trapPkg::word_t    mtimecmp_i
);
    import trapPkg::*;

    logic  ack;
    logic  access;
    word_t rdata;

    // No access is started while ack is up, so ack never repeats
    assign access = wbCyc_i & wbStb_i & ~ack;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    // Write lands on the edge that raises ack
    assign req_o.wr    = access & wbWe_i;
    assign req_o.addr  = wbAdr_i;
    assign req_o.wdata = wbDat_i;

    // Timer words live here, the rest come from trapCsr
    always_ff @(posedge clk) begin
        if (access) begin
            case (wbAdr_i)
                REG_MTIME:    rdata <= mtime_i;
                REG_MTIMECMP: rdata <= mtimecmp_i;
                default:      rdata <= csrRdata_i;
            endcase
        end
    end

    assign wbDat_o = rdata;
    assign wbAck_o = ack;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the trapUnit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=simTrapUnit

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module trapUnitTb -Mdir "$BUILD_DIR" -o "$SIM_BIN" -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
fi
exit "$status"

/* sources.f */
hw/trapPkg.sv
hw/excDetect.sv
hw/machineTimer.sv
hw/trapCsr.sv
hw/wbRegBus.sv
hw/trapUnit.sv
bench/trapUnit_checker.sv
bench/trapUnitTb.sv
